/* testbench/spi_wb_stimulus.txt */
// op addr wdata exp_status exp_rdata, all hex
// A1 read, A2 write, B0 buttons then read, C0 check led_o, D0 cut frame, E0 random scratch, FF end
A2 00000000 1234567B 0 00000000
C0 00000000 00000000 0 0000000B
A1 00000000 00000000 0 0000000B
A2 00000000 FFFFFFF5 0 00000000
C0 00000000 00000000 0 00000005
A1 00000600 00000000 0 00010203
A2 00000600 DEADBEEF 0 00000000
A1 00000600 00000000 0 00010203
E0 00000604 00000000 0 00000000
E0 00000604 00000000 0 00000000
E0 00000604 00000000 0 00000000
B0 00000004 00000000 0 00000000
B0 00000004 00000001 0 00000001
B0 00000004 00000002 0 00000002
B0 00000004 00000003 0 00000003
A1 00000300 00000000 1 00000000
A2 00000300 12345678 1 00000000
D0 00000000 00000000 0 00000000
A1 00000000 00000000 0 00000005
FF 00000000 00000000 0 00000000

/* src.f */
+incdir+common
common/wb_pkg.sv
common/spi_cmd_pkg.sv
spi_bridge/spi_slave.sv
spi_bridge/spi_wb_master.sv
verilog/wb_decoder.sv
verilog/wb_led_regs.sv
verilog/wb_info_regs.sv
verilog/spi_wb_top.sv
testbench/spi_wb_asserts.sv
testbench/tb_spi_wb_top.sv

/* Bender.yml */
package:
  name: spi_wb_bridge

sources:
  - include_dirs:
      - common
    files:
      - common/wb_pkg.sv
      - common/spi_cmd_pkg.sv
      - spi_bridge/spi_slave.sv
      - spi_bridge/spi_wb_master.sv
      - verilog/wb_decoder.sv
      - verilog/wb_led_regs.sv
      - verilog/wb_info_regs.sv
      - verilog/spi_wb_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/spi_wb_asserts.sv
      - testbench/tb_spi_wb_top.sv

/* testbench/tb_spi_wb_top.sv */
`default_nettype none

`include "bridge_defs.svh"

module tb_spi_wb_top
    import spi_cmd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_SCLK  = 8;
    localparam int MAX_TXN    = 32;
    localparam int TXN_WORDS  = 5;
    localparam int RESP_LIMIT = 20;
    localparam int IDLE_LIMIT = 200;

    // Testbench-only operations in the stimulus file
    localparam logic [7:0] OP_BTN     = 8'hB0;
    localparam logic [7:0] OP_LED     = 8'hC0;
    localparam logic [7:0] OP_ABORT   = 8'hD0;
    localparam logic [7:0] OP_SCRATCH = 8'hE0;
    localparam logic [7:0] OP_END     = 8'hFF;

    logic        i_sys_clk;
    logic        rst_n;
    logic        spi_sclk;
    logic        spi_cs_n;
    logic        spi_mosi;
    logic [1:0]  btn;
    wire         spi_miso;
    wire  [3:0]  led;
    wire         bus_active;

    logic [31:0] stim_mem [0:MAX_TXN*TXN_WORDS-1];
    integer      seed;
    logic        done;
    int          idx;
    logic [7:0]  rx;

    initial i_sys_clk = 1'b0;
    always #50 i_sys_clk = ~i_sys_clk;

    spi_wb_top u_spi_wb_top (
        .i_sys_clk    (i_sys_clk),
        .rst_n_i      (rst_n),
        .spi_sclk_i   (spi_sclk),
        .spi_cs_n_i   (spi_cs_n),
        .spi_mosi_i   (spi_mosi),
        .btn_i        (btn),
        .spi_miso_o   (spi_miso),
        .led_o        (led),
        .bus_active_o (bus_active)
    );

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic tick(input int n);
        repeat (n) @(posedge i_sys_clk);
        #5;
    endtask

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Error: %s", reason);
        $display("Simulation failed");
        $fatal(1, "%s", reason);
    endtask

    // ======================================================================
    // SPI host, mode 0, MSB first
    // ======================================================================
    task automatic spi_xfer_byte(input logic [7:0] tx, output logic [7:0] rx_b);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = tx[i];
            tick(HALF_SCLK);
            rx_b[i]  = spi_miso;
            spi_sclk = 1'b1;
            tick(HALF_SCLK);
            spi_sclk = 1'b0;
        end
    endtask

    // Request bytes always see the idle fill on MISO
    task automatic send_req_byte(input logic [7:0] tx);
        logic [7:0] rx_b;
        spi_xfer_byte(tx, rx_b);
        check_val("spi_miso_o during request", rx_b, `SPI_IDLE_FILL);
    endtask

    task automatic cs_select();
        spi_cs_n = 1'b0;
        tick(HALF_SCLK);
    endtask

    task automatic cs_release();
        tick(HALF_SCLK);
        spi_cs_n = 1'b1;
        tick(HALF_SCLK);
    endtask

    task automatic wait_bus_idle();
        int cnt;
        cnt = 0;
        while (bus_active && cnt < IDLE_LIMIT) begin
            tick(1);
            cnt++;
        end
        if (bus_active) begin
            abort_run("bridge did not return to idle after CS release");
        end
    endtask

    task automatic do_frame(input logic [7:0] op, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [7:0] status,
                            output logic [31:0] rdata);
        logic [7:0] rx_b;
        logic [7:0] resp_op;
        int         n;
        resp_op = (op == WRITE_REQ) ? WRITE_RESP : READ_RESP;
        rdata   = '0;
        cs_select();
        send_req_byte(op);
        for (int i = 3; i >= 0; i--) begin
            send_req_byte(addr[8*i +: 8]);
        end
        if (op == WRITE_REQ) begin
            for (int i = 3; i >= 0; i--) begin
                send_req_byte(wdata[8*i +: 8]);
            end
        end
        // Bus latency varies, so hunt for the response opcode
        n    = 0;
        rx_b = 8'h00;
        while (rx_b !== resp_op && n < RESP_LIMIT) begin
            spi_xfer_byte(8'h00, rx_b);
            n++;
        end
        if (rx_b !== resp_op) begin
            abort_run("no response opcode within 20 dummy bytes");
        end
        check_val("bus_active_o", bus_active, 32'd1);
        spi_xfer_byte(8'h00, status);
        if (op == READ_REQ) begin
            for (int i = 3; i >= 0; i--) begin
                spi_xfer_byte(8'h00, rx_b);
                rdata[8*i +: 8] = rx_b;
            end
        end
        cs_release();
        wait_bus_idle();
    endtask

    // ======================================================================
    // One stimulus line
    // ======================================================================
    task automatic run_txn(input logic [7:0] op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp_status,
                           input logic [31:0] exp_data);
        logic [7:0]  status;
        logic [31:0] rdata;
        logic [31:0] rnd;
        case (op)
            READ_REQ, WRITE_REQ: begin
                do_frame(op, addr, wdata, status, rdata);
                check_val($sformatf("status[%08h]", addr), status, exp_status);
                if (op == READ_REQ) begin
                    check_val($sformatf("rdata[%08h]", addr), rdata, exp_data);
                end
            end
            OP_BTN: begin
                btn = wdata[1:0];
                tick(6);
                do_frame(READ_REQ, addr, '0, status, rdata);
                check_val("btn status", status, exp_status);
                check_val("btn readback", rdata, exp_data);
            end
            OP_LED: begin
                check_val("led_o", led, exp_data);
            end
            OP_ABORT: begin
                cs_select();
                send_req_byte(READ_REQ);
                send_req_byte(addr[31:24]);
                send_req_byte(addr[23:16]);
                cs_release();
                wait_bus_idle();
            end
            OP_SCRATCH: begin
                rnd = $random(seed);
                do_frame(WRITE_REQ, addr, rnd, status, rdata);
                check_val("scratch write status", status, exp_status);
                do_frame(READ_REQ, addr, '0, status, rdata);
                check_val("scratch read status", status, exp_status);
                check_val("scratch rdata", rdata, rnd);
            end
            OP_END: begin
                done = 1'b1;
            end
            default: begin
                abort_run("unknown operation in stimulus file");
            end
        endcase
    endtask

    initial begin
        seed     = 60;
        rst_n    = 1'b0;
        spi_sclk = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        btn      = 2'b00;
        done     = 1'b0;
        $readmemh("testbench/spi_wb_stimulus.txt", stim_mem);
        tick(10);
        rst_n = 1'b1;
        tick(4);

        // Idle state after reset
        check_val("led_o", led, 32'd0);
        check_val("bus_active_o", bus_active, 32'd0);
        cs_select();
        spi_xfer_byte(8'h00, rx);
        cs_release();
        check_val("spi_miso_o idle", rx, `SPI_IDLE_FILL);

        idx = 0;
        while (!done && idx < MAX_TXN) begin
            run_txn(stim_mem[idx*TXN_WORDS][7:0], stim_mem[idx*TXN_WORDS+1],
                    stim_mem[idx*TXN_WORDS+2], stim_mem[idx*TXN_WORDS+3],
                    stim_mem[idx*TXN_WORDS+4]);
            idx++;
        end

        if (!done) begin
            abort_run("stimulus file has no end marker");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/spi_wb_asserts.sv */
`default_nettype none

module spi_wb_asserts
    import wb_pkg::*;
#(
    parameter bit CHECK_SEL = 1'b1
)
(
    input wire          i_sys_clk,
    input wire          rst_n_i,
    input wire wb_req_t req_i,
    input wire wb_rsp_t rsp_i,
    input wire [1:0]    slave_stb_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Request held until the slave answers
    a_stb_hold: assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        req_i.stb && !(rsp_i.ack || rsp_i.err) |=> req_i.stb && $stable(req_i.adr))
        else $error("stb dropped or address changed before ack/err");

    a_ack_err_excl: assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        !(rsp_i.ack && rsp_i.err))
        else $error("ack and err asserted together");

    a_rsp_latency: assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        $rose(req_i.stb) |=> rsp_i.ack || rsp_i.err)
        else $error("no ack/err one cycle after stb");

    // Slave strobes exist only behind the decoder
    if (CHECK_SEL) begin : g_one_slave
        a_one_slave: assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
            $onehot0(slave_stb_i))
            else $error("two slaves selected at once");
    end

endmodule

// Master side has no slave selects
bind spi_wb_master spi_wb_asserts #(.CHECK_SEL(1'b0)) u_master_asserts (
    .i_sys_clk   (i_sys_clk),
    .rst_n_i     (rst_n_i),
    .req_i       (wb_req_o),
    .rsp_i       (wb_rsp_i),
    .slave_stb_i (2'b00)
);

bind wb_decoder spi_wb_asserts u_decoder_asserts (
    .i_sys_clk   (i_sys_clk),
    .rst_n_i     (rst_n_i),
    .req_i       (m_req_i),
    .rsp_i       (m_rsp_o),
    .slave_stb_i ({led_req_o.stb, info_req_o.stb})
);

`default_nettype wire

/* verilog/spi_wb_top.sv */
`default_nettype none

`include "bridge_defs.svh"

module spi_wb_top
    import wb_pkg::*;
(
    input  wire         i_sys_clk,
    input  wire         rst_n_i,
    input  wire         spi_sclk_i,
    input  wire         spi_cs_n_i,
    input  wire         spi_mosi_i,
    input  wire [1:0]   btn_i,
    output wire         spi_miso_o,
    output wire [3:0]   led_o,
    output wire         bus_active_o
);

    // SPI byte stream between shifter and bridge
    logic [`SPI_BYTE_W-1:0] rx_byte;
    logic                   rx_valid;
    logic [`SPI_BYTE_W-1:0] tx_byte;
    logic                   tx_load;
    logic                   tx_taken;
    logic                   cs_active;

    // Bus, master side and per slave
    wb_req_t m_req;
    wb_rsp_t m_rsp;
    wb_req_t led_req;
    wb_rsp_t led_rsp;
    wb_req_t info_req;
    wb_rsp_t info_rsp;

    spi_slave u_spi_slave (
        .i_sys_clk   (i_sys_clk),
        .rst_n_i     (rst_n_i),
        .spi_sclk_i  (spi_sclk_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_mosi_i  (spi_mosi_i),
        .tx_byte_i   (tx_byte),
        .tx_load_i   (tx_load),
        .spi_miso_o  (spi_miso_o),
        .rx_byte_o   (rx_byte),
        .rx_valid_o  (rx_valid),
        .tx_taken_o  (tx_taken),
        .cs_active_o (cs_active)
    );

    spi_wb_master u_spi_wb_master (
        .i_sys_clk    (i_sys_clk),
        .rst_n_i      (rst_n_i),
        .rx_byte_i    (rx_byte),
        .rx_valid_i   (rx_valid),
        .tx_taken_i   (tx_taken),
        .cs_active_i  (cs_active),
        .wb_rsp_i     (m_rsp),
        .tx_byte_o    (tx_byte),
        .tx_load_o    (tx_load),
        .wb_req_o     (m_req),
        .bus_active_o (bus_active_o)
    );

    wb_decoder u_wb_decoder (
        .i_sys_clk  (i_sys_clk),
        .rst_n_i    (rst_n_i),
        .m_req_i    (m_req),
        .led_rsp_i  (led_rsp),
        .info_rsp_i (info_rsp),
        .m_rsp_o    (m_rsp),
        .led_req_o  (led_req),
        .info_req_o (info_req)
    );

    wb_led_regs u_wb_led_regs (
        .i_sys_clk (i_sys_clk),
        .rst_n_i   (rst_n_i),
        .wb_req_i  (led_req),
        .btn_i     (btn_i),
        .wb_rsp_o  (led_rsp),
        .led_o     (led_o)
    );

    wb_info_regs u_wb_info_regs (
        .i_sys_clk (i_sys_clk),
        .rst_n_i   (rst_n_i),
        .wb_req_i  (info_req),
        .wb_rsp_o  (info_rsp)
    );

endmodule

`default_nettype wire

/* verilog/wb_info_regs.sv */
`default_nettype none

`include "bridge_defs.svh"

module wb_info_regs
    import wb_pkg::*;
(
    input  wire             i_sys_clk,
    input  wire             rst_n_i,
    input  wire wb_req_t    wb_req_i,
    output wb_rsp_t         wb_rsp_o
);

    logic                  access;
    logic [7:0]            ofs;
    logic                  ack_q;
    logic [`WB_DATA_W-1:0] scratch_q;
    logic [`WB_DATA_W-1:0] rdata_q;

    assign access = wb_req_i.stb & wb_req_i.cyc & ~ack_q;
    assign ofs    = wb_req_i.adr[7:0];

    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            scratch_q <= '0;
        end else begin
            ack_q <= access;
            // Version word is read-only
            if (access && wb_req_i.we && ofs == `REG_OFS_1) begin
                scratch_q <= wb_req_i.dat;
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (access) begin
            case (ofs)
                `REG_OFS_0: rdata_q <= `VERSION_ID;
                `REG_OFS_1: rdata_q <= scratch_q;
                default:    rdata_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

/* verilog/wb_led_regs.sv */
`default_nettype none

`include "bridge_defs.svh"

module wb_led_regs
    import wb_pkg::*;
(
    input  wire             i_sys_clk,
    input  wire             rst_n_i,
    input  wire wb_req_t    wb_req_i,
    input  wire [1:0]       btn_i,
    output wb_rsp_t         wb_rsp_o,
    output logic [3:0]      led_o
);

    logic [`SYNC_STAGES-1:0][1:0] btn_sync;
    logic                         access;
    logic [7:0]                   ofs;
    logic                         ack_q;
    logic [`WB_DATA_W-1:0]        rdata_q;

    // Button inputs are asynchronous
    always_ff @(posedge i_sys_clk) begin
        btn_sync <= {btn_sync[`SYNC_STAGES-2:0], btn_i};
    end

    // Access is blocked while ack is out so each ack lasts one cycle
    assign access = wb_req_i.stb & wb_req_i.cyc & ~ack_q;
    assign ofs    = wb_req_i.adr[7:0];

    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            led_o <= '0;
        end else begin
            ack_q <= access;
            if (access && wb_req_i.we && ofs == `REG_OFS_0) begin
                led_o <= wb_req_i.dat[3:0];
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (access) begin
            case (ofs)
                `REG_OFS_0: rdata_q <= {{(`WB_DATA_W-4){1'b0}}, led_o};
                `REG_OFS_1: rdata_q <= {{(`WB_DATA_W-2){1'b0}}, btn_sync[`SYNC_STAGES-1]};
                default:    rdata_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

/* verilog/wb_decoder.sv */
`default_nettype none

`include "bridge_defs.svh"

module wb_decoder
    import wb_pkg::*;
(
    input  wire             i_sys_clk,
    input  wire             rst_n_i,
    input  wire wb_req_t    m_req_i,
    input  wire wb_rsp_t    led_rsp_i,
    input  wire wb_rsp_t    info_rsp_i,
    output wb_rsp_t         m_rsp_o,
    output wb_req_t         led_req_o,
    output wb_req_t         info_req_o
);

    logic led_sel;
    logic info_sel;
    logic err_q;

    assign led_sel  = ((m_req_i.adr & `SLAVE_ADDR_MASK) == `LED_BASE);
    assign info_sel = ((m_req_i.adr & `SLAVE_ADDR_MASK) == `INFO_BASE);

    // Only the selected slave sees the strobe
    always_comb begin
        led_req_o      = m_req_i;
        led_req_o.stb  = m_req_i.stb & led_sel;
        led_req_o.cyc  = m_req_i.cyc & led_sel;
        info_req_o     = m_req_i;
        info_req_o.stb = m_req_i.stb & info_sel;
        info_req_o.cyc = m_req_i.cyc & info_sel;
    end

    // Unmapped address, one-cycle err like a slave ack
    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= m_req_i.stb & m_req_i.cyc & ~led_sel & ~info_sel & ~err_q;
        end
    end

    always_comb begin
        if (led_sel) begin
            m_rsp_o = led_rsp_i;
        end else if (info_sel) begin
            m_rsp_o = info_rsp_i;
        end else begin
            m_rsp_o = '{dat: '0, ack: 1'b0, err: err_q};
        end
    end

endmodule

`default_nettype wire

/* spi_bridge/spi_wb_master.sv */
`default_nettype none

`include "bridge_defs.svh"

module spi_wb_master
    import wb_pkg::*;
    import spi_cmd_pkg::*;
(
    input  wire                     i_sys_clk,
    input  wire                     rst_n_i,
    input  wire [`SPI_BYTE_W-1:0]   rx_byte_i,
    input  wire                     rx_valid_i,
    input  wire                     tx_taken_i,
    input  wire                     cs_active_i,
    input  wire wb_rsp_t            wb_rsp_i,
    output logic [`SPI_BYTE_W-1:0]  tx_byte_o,
    output logic                    tx_load_o,
    output wb_req_t                 wb_req_o,
    output logic                    bus_active_o
);

    // Status byte followed by the read word
    localparam int RESP_W     = `SPI_BYTE_W + `WB_DATA_W;
    localparam int RESP_BYTES = RESP_W / `SPI_BYTE_W;

    frame_state_t               state;
    logic [1:0]                 byte_cnt;
    logic                       is_write_q;
    logic                       cyc_q;
    logic [2:0]                 resp_left;
    logic [`WB_ADDR_W-1:0]      addr_q;
    logic [`WB_DATA_W-1:0]      wdata_q;
    logic [RESP_W-1:0]          resp_buf;
    logic                       rx_last;
    logic                       bus_done;
    logic                       take_next;

    assign rx_last  = rx_valid_i & (byte_cnt == 2'd3);
    assign bus_done = cyc_q & (wb_rsp_i.ack | wb_rsp_i.err);

    // A take in the same cycle as a load shifted out the old byte,
    // so the freshly loaded one is still pending
    assign take_next = tx_taken_i & ~tx_load_o;

    // ==================================================================
    // Frame FSM
    // ==================================================================
    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            state      <= ST_OPCODE;
            byte_cnt   <= '0;
            is_write_q <= 1'b0;
            cyc_q      <= 1'b0;
            resp_left  <= '0;
            tx_load_o  <= 1'b0;
        end else begin
            tx_load_o <= 1'b0;
            // CS release drops the frame, but never a cycle on the bus
            if (!cs_active_i && state != ST_BUS) begin
                state <= ST_OPCODE;
            end else begin
                case (state)
                    ST_OPCODE: begin
                        if (rx_valid_i && (rx_byte_i == READ_REQ || rx_byte_i == WRITE_REQ)) begin
                            is_write_q <= (rx_byte_i == WRITE_REQ);
                            byte_cnt   <= '0;
                            state      <= ST_ADDR;
                        end
                    end
                    ST_ADDR: begin
                        if (rx_valid_i) begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                        if (rx_last && is_write_q) begin
                            state <= ST_DATA;
                        end else if (rx_last) begin
                            state <= ST_BUS;
                            cyc_q <= 1'b1;
                        end
                    end
                    ST_DATA: begin
                        if (rx_valid_i) begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                        if (rx_last) begin
                            state <= ST_BUS;
                            cyc_q <= 1'b1;
                        end
                    end
                    ST_BUS: begin
                        if (bus_done) begin
                            cyc_q     <= 1'b0;
                            resp_left <= is_write_q ? 3'd1 : 3'(RESP_BYTES);
                            tx_load_o <= cs_active_i;
                            state     <= cs_active_i ? ST_RESPOND : ST_OPCODE;
                        end
                    end
                    ST_RESPOND: begin
                        if (take_next && resp_left == '0) begin
                            state <= ST_OPCODE;
                        end else if (take_next) begin
                            resp_left <= resp_left - 1'b1;
                            tx_load_o <= 1'b1;
                        end
                    end
                    default: state <= ST_OPCODE;
                endcase
            end
        end
    end

    // ==================================================================
    // Address, write data and response bytes
    // ==================================================================
    always_ff @(posedge i_sys_clk) begin
        if (rx_valid_i && state == ST_ADDR) begin
            addr_q <= {addr_q[`WB_ADDR_W-`SPI_BYTE_W-1:0], rx_byte_i};
        end
        if (rx_valid_i && state == ST_DATA) begin
            wdata_q <= {wdata_q[`WB_DATA_W-`SPI_BYTE_W-1:0], rx_byte_i};
        end

        if (state == ST_BUS && bus_done) begin
            // Read data is forced to zero on a bus error
            resp_buf  <= {{(`SPI_BYTE_W-1){1'b0}}, wb_rsp_i.err,
                          wb_rsp_i.dat & {`WB_DATA_W{~wb_rsp_i.err}}};
            tx_byte_o <= is_write_q ? WRITE_RESP : READ_RESP;
        end else if (state == ST_RESPOND && take_next && resp_left != '0) begin
            tx_byte_o <= resp_buf[RESP_W-1 -: `SPI_BYTE_W];
            resp_buf  <= resp_buf << `SPI_BYTE_W;
        end
    end

    assign wb_req_o = '{adr: addr_q, dat: wdata_q, we: is_write_q, stb: cyc_q, cyc: cyc_q};

    // High from a valid opcode until the last response byte is handed off
    assign bus_active_o = (state != ST_OPCODE);

endmodule

`default_nettype wire

/* spi_bridge/spi_slave.sv */
`default_nettype none

`include "bridge_defs.svh"

module spi_slave (
    input  wire                     i_sys_clk,
    input  wire                     rst_n_i,
    input  wire                     spi_sclk_i,
    input  wire                     spi_cs_n_i,
    input  wire                     spi_mosi_i,
    input  wire [`SPI_BYTE_W-1:0]   tx_byte_i,
    input  wire                     tx_load_i,
    output logic                    spi_miso_o,
    output logic [`SPI_BYTE_W-1:0]  rx_byte_o,
    output logic                    rx_valid_o,
    output logic                    tx_taken_o,
    output logic                    cs_active_o
);

    localparam int BIT_CNT_W = $clog2(`SPI_BYTE_W);

    // One extra stage on SCLK and CS holds the previous level for edge detect
    logic [`SYNC_STAGES:0]     sclk_q;
    logic [`SYNC_STAGES:0]     cs_n_q;
    logic [`SYNC_STAGES-1:0]   mosi_q;
    logic                      mosi_s;
    logic                      sclk_rise;
    logic                      sclk_fall;
    logic                      cs_start;
    logic                      byte_end;
    logic [BIT_CNT_W-1:0]      bit_cnt;
    logic [`SPI_BYTE_W-1:0]    rx_shift;
    logic [`SPI_BYTE_W-1:0]    tx_shift;
    logic [`SPI_BYTE_W-1:0]    tx_pending;

    // ==================================================================
    // Synchronizers and edge detection
    // ==================================================================
    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            sclk_q <= '0;
            cs_n_q <= '1;
        end else begin
            sclk_q <= {sclk_q[`SYNC_STAGES-1:0], spi_sclk_i};
            cs_n_q <= {cs_n_q[`SYNC_STAGES-1:0], spi_cs_n_i};
        end
    end

    always_ff @(posedge i_sys_clk) begin
        mosi_q <= {mosi_q[`SYNC_STAGES-2:0], spi_mosi_i};
    end

    assign cs_active_o = ~cs_n_q[`SYNC_STAGES-1];
    assign mosi_s      = mosi_q[`SYNC_STAGES-1];
    assign sclk_rise   = cs_active_o & sclk_q[`SYNC_STAGES-1] & ~sclk_q[`SYNC_STAGES];
    assign sclk_fall   = cs_active_o & ~sclk_q[`SYNC_STAGES-1] & sclk_q[`SYNC_STAGES];
    assign cs_start    = cs_active_o & cs_n_q[`SYNC_STAGES];
    assign byte_end    = (bit_cnt == BIT_CNT_W'(`SPI_BYTE_W - 1));

    // ==================================================================
    // Receive path, MOSI sampled on rising SCLK
    // ==================================================================
    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (!cs_active_o) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                // Counter wraps to zero after the last bit
                bit_cnt    <= bit_cnt + 1'b1;
                rx_valid_o <= byte_end;
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[`SPI_BYTE_W-2:0], mosi_s};
            if (byte_end) begin
                rx_byte_o <= {rx_shift[`SPI_BYTE_W-2:0], mosi_s};
            end
        end
    end

    // ==================================================================
    // Transmit path, MISO shifted on falling SCLK
    // ==================================================================

    // New byte enters the shifter at CS fall and after each full byte
    assign tx_taken_o = cs_start | (sclk_fall & (bit_cnt == '0));

    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            tx_shift   <= `SPI_IDLE_FILL;
            tx_pending <= `SPI_IDLE_FILL;
        end else begin
            if (tx_taken_o) begin
                tx_shift <= tx_pending;
            end else if (sclk_fall) begin
                tx_shift <= {tx_shift[`SPI_BYTE_W-2:0], 1'b1};
            end

            if (tx_load_i) begin
                tx_pending <= tx_byte_i;
            end else if (tx_taken_o || !cs_active_o) begin
                tx_pending <= `SPI_IDLE_FILL;
            end
        end
    end

    assign spi_miso_o = tx_shift[`SPI_BYTE_W-1];

endmodule

`default_nettype wire

/* common/spi_cmd_pkg.sv */
`default_nettype none

`include "bridge_defs.svh"

package spi_cmd_pkg;

    // Opcode bytes at the start of request and response frames
    typedef enum logic [`SPI_BYTE_W-1:0] {
        READ_REQ   = 8'hA1,
        WRITE_REQ  = 8'hA2,
        READ_RESP  = 8'hA3,
        WRITE_RESP = 8'hA4
    } cmd_op_t;

    // Bridge frame parser
    typedef enum logic [2:0] {
        ST_OPCODE,
        ST_ADDR,
        ST_DATA,
        ST_BUS,
        ST_RESPOND
    } frame_state_t;

endpackage

`default_nettype wire

/* common/wb_pkg.sv */
`default_nettype none

`include "bridge_defs.svh"

package wb_pkg;

    // Master to slave, stb and cyc always travel together
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] dat;
        logic                  we;
        logic                  stb;
        logic                  cyc;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic [`WB_DATA_W-1:0] dat;
        logic                  ack;
        logic                  err;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* common/bridge_defs.svh */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// Bus and SPI widths
`define WB_ADDR_W         32
`define WB_DATA_W         32
`define SPI_BYTE_W        8

// Address map, each slave owns one 256-byte window
`define LED_BASE          32'h0000_0000
`define INFO_BASE         32'h0000_0600
`define SLAVE_ADDR_MASK   32'hFFFF_FF00

// Register offsets inside a window
`define REG_OFS_0         8'h00
`define REG_OFS_1         8'h04

`define VERSION_ID        32'h0001_0203

// Depth of the input synchronizers
`define SYNC_STAGES       2

// Shifted out on MISO while no response byte is queued
`define SPI_IDLE_FILL     8'hFF

`endif
